// ==== common/nibble_cpu_defs.svh ====
`ifndef NIBBLE_CPU_DEFS_SVH
`define NIBBLE_CPU_DEFS_SVH

// data word width
`define NCPU_XLEN 32

// alu passes per operation, one nibble each
`define NCPU_NIBBLES 8

// program ram depth in words
`define NCPU_RAM_WORDS 64

// byte address of the first instruction
`define NCPU_START_ADDR 32'h0000_0000

`endif

// ==== common/nibble_cpu_pkg.sv ====
`default_nettype none

`include "nibble_cpu_defs.svh"

package nibble_cpu_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_lui = 7'b0110111,
        op_imm = 7'b0010011,
        op_reg = 7'b0110011
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add    = 3'd0,
        alu_sub    = 3'd1,
        alu_xor    = 3'd2,
        alu_or     = 3'd3,
        alu_and    = 3'd4,
        alu_pass_b = 3'd5
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_type_t;

    // one fetched word, three formats
    typedef union packed {
        r_type_t r;
        i_type_t i;
        u_type_t u;
    } instr_u;

    typedef struct packed {
        alu_op_e               alu_op;
        logic [4:0]            rs1;
        logic [4:0]            rs2;
        logic [4:0]            rd;
        logic                  use_imm;
        logic [`NCPU_XLEN-1:0] imm;
        logic                  illegal;
    } decoded_t;

    typedef struct packed {
        logic                                valid;
        logic [$clog2(`NCPU_RAM_WORDS)-1:0] addr;
        logic [`NCPU_XLEN-1:0]               data;
    } load_t;

    typedef struct packed {
        logic                  valid;
        logic [`NCPU_XLEN-1:0] pc;
        logic [4:0]            rd;
        logic [`NCPU_XLEN-1:0] value;
    } retire_t;

    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_decode,
        st_execute,
        st_writeback,
        st_halted
    } cpu_state_e;

endpackage

`default_nettype wire

// ==== control/instr_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "nibble_cpu_defs.svh"

module instr_decoder import nibble_cpu_pkg::*; (
    input  instr_u   instr,
    output decoded_t decoded
);

    always_comb begin
        decoded         = '0;
        decoded.alu_op  = alu_add;
        decoded.rd      = instr.r.rd;

        case (instr.r.opcode)
            op_lui: begin
                // upper immediate goes straight through the alu
                decoded.alu_op  = alu_pass_b;
                decoded.rd      = instr.u.rd;
                decoded.use_imm = 1'b1;
                decoded.imm     = {instr.u.imm, 12'h000};
            end

            op_imm: begin
                decoded.rs1     = instr.i.rs1;
                decoded.rd      = instr.i.rd;
                decoded.use_imm = 1'b1;
                decoded.imm     = {{(`NCPU_XLEN-12){instr.i.imm[11]}}, instr.i.imm};
                case (instr.i.funct3)
                    3'b000:  decoded.alu_op = alu_add;
                    3'b100:  decoded.alu_op = alu_xor;
                    3'b110:  decoded.alu_op = alu_or;
                    3'b111:  decoded.alu_op = alu_and;
                    default: decoded.illegal = 1'b1;
                endcase
            end

            op_reg: begin
                decoded.rs1 = instr.r.rs1;
                decoded.rs2 = instr.r.rs2;
                decoded.rd  = instr.r.rd;
                if (instr.r.funct7 == 7'b0000000) begin
                    case (instr.r.funct3)
                        3'b000:  decoded.alu_op = alu_add;
                        3'b100:  decoded.alu_op = alu_xor;
                        3'b110:  decoded.alu_op = alu_or;
                        3'b111:  decoded.alu_op = alu_and;
                        default: decoded.illegal = 1'b1;
                    endcase
                end else if (instr.r.funct7 == 7'b0100000 && instr.r.funct3 == 3'b000) begin
                    decoded.alu_op = alu_sub;
                end else begin
                    decoded.illegal = 1'b1;
                end
            end

            // everything else stops the core, the zero word included
            default: decoded.illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// ==== control/control.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "nibble_cpu_defs.svh"

module control import nibble_cpu_pkg::*; (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                run,
    output logic [$clog2(`NCPU_RAM_WORDS)-1:0] fetch_addr,
    input  instr_u                              fetch_data,
    input  decoded_t                            decoded,
    output instr_u                              instr,
    input  logic [`NCPU_XLEN-1:0]               rs1_data,
    input  logic [`NCPU_XLEN-1:0]               rs2_data,
    output logic                                alu_start,
    output alu_op_e                             alu_op,
    output logic [`NCPU_XLEN-1:0]               operand_a,
    output logic [`NCPU_XLEN-1:0]               operand_b,
    input  logic                                alu_done,
    input  logic [`NCPU_XLEN-1:0]               alu_result,
    output logic                                wr_en,
    output logic [4:0]                          wr_addr,
    output logic [`NCPU_XLEN-1:0]               wr_data,
    output retire_t                             retire,
    output logic                                halted
);

    localparam int ADDR_W = $clog2(`NCPU_RAM_WORDS);

    cpu_state_e            state;
    cpu_state_e            state_next;
    logic [`NCPU_XLEN-1:0] pc;
    logic [`NCPU_XLEN-1:0] result_q;
    instr_u                ir;
    logic                  run_q;
    logic                  run_rise;

    assign run_rise = run & ~run_q;

    always_comb begin
        state_next = state;
        case (state)
            st_idle:      if (run_rise) state_next = st_fetch;
            st_fetch:     state_next = st_decode;
            st_decode:    state_next = decoded.illegal ? st_halted : st_execute;
            st_execute:   if (alu_done) state_next = st_writeback;
            st_writeback: state_next = st_fetch;
            st_halted:    state_next = st_halted;
            default:      state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= st_idle;
            pc        <= `NCPU_START_ADDR;
            run_q     <= 1'b0;
            alu_start <= 1'b0;
        end else begin
            state <= state_next;
            run_q <= run;
            // start lands on the first execute cycle
            alu_start <= (state == st_decode) && !decoded.illegal;
            if (state == st_idle && run_rise) begin
                pc <= `NCPU_START_ADDR;
            end else if (state == st_writeback) begin
                pc <= pc + `NCPU_XLEN'(4);
            end
        end
    end

    // instruction and operand latches
    always_ff @(posedge clk) begin
        if (state == st_decode) begin
            ir        <= fetch_data;
            alu_op    <= decoded.alu_op;
            operand_a <= rs1_data;
            operand_b <= decoded.use_imm ? decoded.imm : rs2_data;
        end
        if (state == st_execute && alu_done) begin
            result_q <= alu_result;
        end
    end

    // ram data arrives during decode, the latched copy after that
    assign instr      = (state == st_decode) ? fetch_data : ir;
    assign fetch_addr = pc[ADDR_W+1:2];

    assign wr_en   = (state == st_writeback);
    assign wr_addr = decoded.rd;
    assign wr_data = result_q;

    always_comb begin
        retire.valid = wr_en;
        retire.pc    = pc;
        retire.rd    = wr_addr;
        retire.value = wr_data;
    end

    assign halted = (state == st_halted);

endmodule

`default_nettype wire

// ==== alu/nibble_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "nibble_cpu_defs.svh"

module nibble_alu import nibble_cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  alu_op_e               alu_op,
    input  logic [`NCPU_XLEN-1:0] operand_a,
    input  logic [`NCPU_XLEN-1:0] operand_b,
    output logic                  done,
    output logic [`NCPU_XLEN-1:0] result
);

    localparam int CNT_W = $clog2(`NCPU_NIBBLES);

    logic [`NCPU_XLEN-1:0] a_sr;
    logic [`NCPU_XLEN-1:0] b_sr;
    logic [`NCPU_XLEN-1:0] res_sr;
    logic [`NCPU_XLEN-1:0] a_cur;
    logic [`NCPU_XLEN-1:0] b_cur;
    alu_op_e               op_q;
    alu_op_e               op_cur;
    logic                  carry_q;
    logic                  carry_in;
    logic                  carry;
    logic [CNT_W-1:0]      cnt_q;
    logic                  busy;
    logic                  active;
    logic [3:0]            a_nib;
    logic [3:0]            b_nib;
    logic [3:0]            sum_nib;
    logic [3:0]            nib_out;

    // the start cycle already handles nibble 0
    assign active   = start | busy;
    assign op_cur   = start ? alu_op : op_q;
    assign a_cur    = start ? operand_a : a_sr;
    assign b_cur    = start ? operand_b : b_sr;
    assign carry_in = start ? (alu_op == alu_sub) : carry_q;

    assign a_nib = a_cur[3:0];
    assign b_nib = (op_cur == alu_sub) ? ~b_cur[3:0] : b_cur[3:0];

    // ripple of four full adders
    always_comb begin
        carry = carry_in;
        for (int i = 0; i < 4; i++) begin
            sum_nib[i] = a_nib[i] ^ b_nib[i] ^ carry;
            carry      = (a_nib[i] & b_nib[i]) | (carry & (a_nib[i] ^ b_nib[i]));
        end
    end

    always_comb begin
        case (op_cur)
            alu_add, alu_sub: nib_out = sum_nib;
            alu_xor:          nib_out = a_nib ^ b_nib;
            alu_or:           nib_out = a_nib | b_nib;
            alu_and:          nib_out = a_nib & b_nib;
            alu_pass_b:       nib_out = b_nib;
            default:          nib_out = 4'h0;
        endcase
    end

    assign done   = busy && (cnt_q == CNT_W'(`NCPU_NIBBLES - 1));
    assign result = {nib_out, res_sr[`NCPU_XLEN-1:4]};

    always_ff @(posedge clk) begin
        if (reset) begin
            busy    <= 1'b0;
            cnt_q   <= '0;
            carry_q <= 1'b0;
            op_q    <= alu_add;
        end else begin
            busy <= start | (busy & ~done);
            if (active) begin
                carry_q <= carry;
                cnt_q   <= start ? CNT_W'(1) : cnt_q + 1'b1;
            end
            if (start) begin
                op_q <= alu_op;
            end
        end
    end

    // operands shift down, result fills from the top
    always_ff @(posedge clk) begin
        if (active) begin
            a_sr   <= a_cur >> 4;
            b_sr   <= b_cur >> 4;
            res_sr <= {nib_out, res_sr[`NCPU_XLEN-1:4]};
        end
    end

endmodule

`default_nettype wire

// ==== source/register_file.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "nibble_cpu_defs.svh"

module register_file import nibble_cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [4:0]            rs1,
    input  logic [4:0]            rs2,
    output logic [`NCPU_XLEN-1:0] rs1_data,
    output logic [`NCPU_XLEN-1:0] rs2_data,
    input  logic                  wr_en,
    input  logic [4:0]            wr_addr,
    input  logic [`NCPU_XLEN-1:0] wr_data
);

    logic [`NCPU_XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != 5'd0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // x0 reads zero
    assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== source/program_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "nibble_cpu_defs.svh"

module program_ram import nibble_cpu_pkg::*; (
    input  logic                                clk,
    input  load_t                               load,
    input  logic [$clog2(`NCPU_RAM_WORDS)-1:0] fetch_addr,
    output instr_u                              fetch_data
);

    logic [`NCPU_XLEN-1:0] mem [`NCPU_RAM_WORDS];

    // load port, only used while the core sits idle
    always_ff @(posedge clk) begin
        if (load.valid) begin
            mem[load.addr] <= load.data;
        end
    end

    // fetch data shows up one cycle after the address
    always_ff @(posedge clk) begin
        fetch_data <= mem[fetch_addr];
    end

endmodule

`default_nettype wire

// ==== source/nibble_cpu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "nibble_cpu_defs.svh"

module nibble_cpu_top import nibble_cpu_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  load_t   load,
    input  logic    run,
    output retire_t retire,
    output logic    halted
);

    logic [$clog2(`NCPU_RAM_WORDS)-1:0] fetch_addr;
    instr_u                              fetch_data;
    instr_u                              instr;
    decoded_t                            decoded;
    logic [`NCPU_XLEN-1:0]               rs1_data;
    logic [`NCPU_XLEN-1:0]               rs2_data;
    logic                                alu_start;
    alu_op_e                             alu_op;
    logic [`NCPU_XLEN-1:0]               operand_a;
    logic [`NCPU_XLEN-1:0]               operand_b;
    logic                                alu_done;
    logic [`NCPU_XLEN-1:0]               alu_result;
    logic                                wr_en;
    logic [4:0]                          wr_addr;
    logic [`NCPU_XLEN-1:0]               wr_data;

    program_ram u_ram (
        .clk        (clk),
        .load       (load),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data)
    );

    control u_control (
        .clk        (clk),
        .reset      (reset),
        .run        (run),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data),
        .decoded    (decoded),
        .instr      (instr),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .alu_start  (alu_start),
        .alu_op     (alu_op),
        .operand_a  (operand_a),
        .operand_b  (operand_b),
        .alu_done   (alu_done),
        .alu_result (alu_result),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .retire     (retire),
        .halted     (halted)
    );

    instr_decoder u_decoder (
        .instr   (instr),
        .decoded (decoded)
    );

    nibble_alu u_alu (
        .clk       (clk),
        .reset     (reset),
        .start     (alu_start),
        .alu_op    (alu_op),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .done      (alu_done),
        .result    (alu_result)
    );

    // read ports addressed straight from the decoder
    register_file u_regs (
        .clk      (clk),
        .reset    (reset),
        .rs1      (decoded.rs1),
        .rs2      (decoded.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

endmodule

`default_nettype wire

// ==== testbench/retire_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "nibble_cpu_defs.svh"

module retire_checker import nibble_cpu_pkg::*; #(
    parameter int N_INSTR = 40,
    parameter int SPACING = 11
) (
    input  logic                  clk,
    input  logic                  reset,
    input  retire_t               retire,
    input  logic                  halted,
    input  logic                  end_check,
    input  logic [`NCPU_XLEN-1:0] prog [`NCPU_RAM_WORDS],
    output int                    error_count,
    output int                    retire_count
);

    localparam int AW = $clog2(`NCPU_RAM_WORDS);

    logic [`NCPU_XLEN-1:0] model [32];
    logic [`NCPU_XLEN-1:0] exp_pc;
    logic                  halt_seen;
    int                    cycle;
    int                    last_retire;

    // reference behavior of the rv32i subset, returns 0 for a halting word
    function automatic logic execute_model(input logic [31:0] word, input logic [31:0] a,
                                           input logic [31:0] b, output logic [31:0] value);
        logic [31:0] imm;
        logic [31:0] opnd;
        logic        legal;
        imm   = {{20{word[31]}}, word[31:20]};
        legal = 1'b1;
        value = '0;
        opnd  = (word[6:0] == 7'b0010011) ? imm : b;
        case (word[6:0])
            7'b0110111: value = {word[31:12], 12'h000};
            7'b0010011, 7'b0110011: begin
                if (word[5] && word[31:25] == 7'h20 && word[14:12] == 3'b000) begin
                    value = a - b;
                end else if (word[5] && word[31:25] != 7'h00) begin
                    legal = 1'b0;
                end else begin
                    case (word[14:12])
                        3'b000:  value = a + opnd;
                        3'b100:  value = a ^ opnd;
                        3'b110:  value = a | opnd;
                        3'b111:  value = a & opnd;
                        default: legal = 1'b0;
                    endcase
                end
            end
            default: legal = 1'b0;
        endcase
        return legal;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
        error_count++;
    endtask

    task automatic report_failure(input string what);
        $display("error at %0t: %s", $time, what);
        error_count++;
    endtask

    task automatic check_retire();
        logic [31:0] word;
        logic [31:0] value;
        logic        legal;
        word  = prog[exp_pc[AW+1:2]];
        legal = execute_model(word, model[word[19:15]], model[word[24:20]], value);
        if (halt_seen) report_failure("instruction retired after the core halted");
        if (!legal) report_failure($sformatf("word %h retired instead of halting", word));
        if (retire_count > 0 && cycle - last_retire != SPACING) begin
            report_mismatch("retire spacing", SPACING, cycle - last_retire);
        end
        if (retire.pc !== exp_pc) report_mismatch("retire.pc", exp_pc, retire.pc);
        if (retire.rd !== word[11:7]) report_mismatch("retire.rd", word[11:7], retire.rd);
        if (retire.value !== value) report_mismatch("retire.value", value, retire.value);
        // x0 keeps reading zero
        if (word[11:7] != 5'd0) model[word[11:7]] = value;
        exp_pc = exp_pc + 32'd4;
        retire_count++;
        last_retire = cycle;
    endtask

    task automatic check_halt();
        logic [31:0] value;
        halt_seen = 1'b1;
        if (execute_model(prog[exp_pc[AW+1:2]], '0, '0, value)) begin
            report_failure($sformatf("core halted at pc %h on a legal instruction", exp_pc));
        end
    endtask

    task automatic check_end();
        if (!halt_seen) report_failure("core never raised halted");
        else if (!halted) report_failure("halted dropped before reset");
        if (retire_count != N_INSTR) report_mismatch("retire count", N_INSTR, retire_count);
    endtask

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                model[i] = '0;
            end
            exp_pc       = `NCPU_START_ADDR;
            halt_seen    = 1'b0;
            cycle        = 0;
            last_retire  = 0;
            error_count  = 0;
            retire_count = 0;
        end else begin
            cycle++;
            if (retire.valid) check_retire();
            if (halted && !halt_seen) check_halt();
            if (end_check) check_end();
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_nibble_cpu.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "nibble_cpu_defs.svh"

module tb_nibble_cpu import nibble_cpu_pkg::*; ();

    localparam int AW           = $clog2(`NCPU_RAM_WORDS);
    localparam int N_INSTR      = 40;
    localparam int PROG_WORDS   = N_INSTR + 1;
    localparam int RESET_CYCLES = 4;
    localparam int SPACING      = 11;
    localparam int TIMEOUT      = N_INSTR * SPACING + RESET_CYCLES + PROG_WORDS + 100;

    logic                  clk;
    logic                  reset;
    load_t                 load;
    logic                  run;
    retire_t               retire;
    logic                  halted;
    logic                  end_check;
    logic [`NCPU_XLEN-1:0] prog [`NCPU_RAM_WORDS];
    int                    error_count;
    int                    retire_count;
    int                    cycles;

    nibble_cpu_top dut (
        .clk    (clk),
        .reset  (reset),
        .load   (load),
        .run    (run),
        .retire (retire),
        .halted (halted)
    );

    retire_checker #(.N_INSTR(N_INSTR), .SPACING(SPACING)) u_checker (
        .clk          (clk),
        .reset        (reset),
        .retire       (retire),
        .halted       (halted),
        .end_check    (end_check),
        .prog         (prog),
        .error_count  (error_count),
        .retire_count (retire_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // small register pool so results feed later instructions
    function automatic logic [4:0] pick_reg();
        logic [4:0] r;
        r = 5'($urandom % 8);
        if ($urandom % 4 == 0) r = 5'($urandom % 32);
        return r;
    endfunction

    function automatic logic [31:0] random_instr();
        logic [2:0] f3;
        logic [6:0] f7;
        int         kind;
        kind = $urandom % 3;
        f7   = 7'h00;
        case ($urandom % 4)
            0:       f3 = 3'b000;
            1:       f3 = 3'b100;
            2:       f3 = 3'b110;
            default: f3 = 3'b111;
        endcase
        if (kind == 0) return {20'($urandom), pick_reg(), 7'b0110111};
        if (kind == 1) return {12'($urandom), pick_reg(), f3, pick_reg(), 7'b0010011};
        if ($urandom % 4 == 0) begin
            f3 = 3'b000;
            f7 = 7'h20;
        end
        return {f7, pick_reg(), pick_reg(), f3, pick_reg(), 7'b0110011};
    endfunction

    initial begin
        void'($urandom(30571));
        reset     = 1'b1;
        run       = 1'b0;
        load      = '0;
        end_check = 1'b0;
        // program ends in the all-zero word
        for (int i = 0; i < `NCPU_RAM_WORDS; i++) begin
            prog[i] = (i < N_INSTR) ? random_instr() : 32'h0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < PROG_WORDS; i++) begin
            @(negedge clk);
            load.valid = 1'b1;
            load.addr  = AW'(i);
            load.data  = prog[i];
        end
        @(negedge clk);
        load = '0;
        run  = 1'b1;
        while (!halted) @(negedge clk);
        // watch a while longer for stray retirements
        repeat (2 * SPACING) @(negedge clk);
        end_check = 1'b1;
        @(negedge clk);
        end_check = 1'b0;
        @(negedge clk);
        $display("run complete: %0d retirements, %0d errors", retire_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: core did not halt within %0d cycles", TIMEOUT);
        $display("run stopped: %0d retirements, %0d errors", retire_count, error_count + 1);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+common
common/nibble_cpu_pkg.sv
control/instr_decoder.sv
control/control.sv
alu/nibble_alu.sv
source/register_file.sv
source/program_ram.sv
source/nibble_cpu_top.sv
testbench/retire_checker.sv
testbench/tb_nibble_cpu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the nibble cpu testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_nibble_cpu \
    -f flist.f -o sim_nibble_cpu

./obj_dir/sim_nibble_cpu > sim.log 2>&1
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation passed"
